// File: project.f
+incdir+logic
logic/cache_pkg.sv
logic/dual_port_lutram.sv
logic/cache_lookup.sv
logic/direct_mapped_cache.sv
testbench/direct_mapped_cache_sva.sv
testbench/tb_direct_mapped_cache.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_direct_mapped_cache
FILELIST = project.f
BUILD    = obj_dir

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// File: testbench/tb_direct_mapped_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module tb_direct_mapped_cache
    import cache_pkg::*;
();

    localparam int TOTAL_REQ       = 300;
    localparam int WATCHDOG_CYCLES = TOTAL_REQ * 20 + 200;
    localparam int NUM_SET         = `CACHE_NUM_SET;
    localparam int LANES           = $bits(cache_mask_t);

    logic        clk_in;
    logic        reset_in;
    logic        req_valid;
    logic        req_ready;
    cache_addr_t req_addr;
    logic        resp_valid;
    logic        resp_ready;
    logic        resp_hit;
    cache_line_t resp_data;
    logic        fill_valid;
    cache_addr_t fill_addr;
    cache_mask_t fill_mask;
    cache_line_t fill_data;

    int seed = 18953;

    // Reference model of the cache contents.
    logic        model_valid [NUM_SET];
    cache_tag_t  model_tag [NUM_SET];
    cache_line_t model_line [NUM_SET];
    logic        full_filled [NUM_SET];

    cache_addr_t addr_q [$];
    logic        exp_hit_q [$];
    cache_line_t exp_data_q [$];
    logic        resp_busy;
    logic        seen_request;

    direct_mapped_cache i_dut
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_hit   (resp_hit),
        .resp_data  (resp_data),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_mask  (fill_mask),
        .fill_data  (fill_data)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    // Half the addresses reuse the stored tag so that hits are common.
    function automatic cache_addr_t pick_addr();
        cache_addr_t a;
        a.index = cache_index_t'($random(seed));
        if (chance(50))
        begin
            a.tag = model_tag[a.index];
        end
        else
        begin
            a.tag = cache_tag_t'($random(seed) & 3);
        end
        return a;
    endfunction

    function automatic void apply_fill(cache_addr_t a, cache_mask_t m, cache_line_t d);
        for (int lane = 0; lane < LANES; lane++)
        begin
            if (m[lane])
            begin
                model_line[a.index][lane*`CACHE_BYTE_BITS +: `CACHE_BYTE_BITS] =
                    d[lane*`CACHE_BYTE_BITS +: `CACHE_BYTE_BITS];
            end
        end
        if (|m)
        begin
            model_valid[a.index] = 1'b1;
            model_tag[a.index]   = a.tag;
        end
    endfunction

    task automatic check_response();
        logic        h;
        cache_line_t d;
        if (exp_hit_q.size() == 0)
        begin
            fail_run("a response was taken with no expected value queued");
        end
        else
        begin
            h = exp_hit_q.pop_front();
            d = exp_data_q.pop_front();
            assert (resp_hit == h)
            else fail_run($sformatf("error: time %0t signal resp_hit expected %0h got %0h",
                                    $time, h, resp_hit));
            if (h)
            begin
                assert (resp_data == d)
                else fail_run($sformatf("error: time %0t signal resp_data expected %0h got %0h",
                                        $time, d, resp_data));
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Monitor sampling at the falling edge what the next rising edge does
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk_in)
    begin
        cache_addr_t a;
        if (!reset_in)
        begin
            if (resp_valid && !seen_request)
            begin
                fail_run("resp_valid went high before any request was accepted");
            end
            // A new item loaded stage two at the last edge; the model holds every fill up to it.
            if (resp_valid && !resp_busy)
            begin
                if (addr_q.size() == 0)
                begin
                    fail_run("a response appeared with no request outstanding");
                end
                else
                begin
                    a = addr_q.pop_front();
                    exp_hit_q.push_back(model_valid[a.index] && (model_tag[a.index] == a.tag));
                    exp_data_q.push_back(model_line[a.index]);
                end
            end
            if (fill_valid)
            begin
                apply_fill(fill_addr, fill_mask, fill_data);
            end
            if (resp_valid && resp_ready)
            begin
                check_response();
            end
            if (req_valid && req_ready)
            begin
                addr_q.push_back(req_addr);
                seen_request = 1'b1;
            end
            resp_busy = resp_valid && !resp_ready;
        end
    end

    // With resp_ready high on the following edge, the response shows two edges after accept.
    assert property (@(posedge clk_in) disable iff (reset_in)
        (resp_ready && $past(req_valid && req_ready)) |=> resp_valid)
    else fail_run("response did not follow an accepted request by two edges");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_phase(input int n_req, input int req_pct, input int fill_pct,
                             input int ready_pct, input bit partial, input bit same_set);
        int          sent;
        bit          hold;
        bit          stalled;
        cache_addr_t a;
        cache_addr_t f;
        cache_addr_t last_acc;
        cache_mask_t m;
        sent     = 0;
        last_acc = '0;
        while (sent < n_req)
        begin
            @(negedge clk_in);
            hold    = req_valid && !req_ready;
            stalled = !req_ready;
            if (req_valid && req_ready)
            begin
                sent++;
                last_acc = req_addr;
            end
            @(posedge clk_in);
            a = req_addr;
            if (!hold)
            begin
                if (sent < n_req && chance(req_pct))
                begin
                    a = pick_addr();
                    req_valid <= 1'b1;
                    req_addr  <= a;
                end
                else
                begin
                    req_valid <= 1'b0;
                end
            end
            if (chance(fill_pct))
            begin
                f = pick_addr();
                // Aim the fill at the stalled item, or at the request on its accept edge.
                if (same_set)
                begin
                    f.index = stalled ? last_acc.index : a.index;
                end
                m = '1;
                if (partial && full_filled[f.index] && chance(60))
                begin
                    m = cache_mask_t'($random(seed));
                end
                else
                begin
                    full_filled[f.index] = 1'b1;
                end
                fill_valid <= 1'b1;
                fill_addr  <= f;
                fill_mask  <= m;
                fill_data  <= {$random(seed), $random(seed)};
            end
            else
            begin
                fill_valid <= 1'b0;
            end
            resp_ready <= chance(ready_pct);
        end
    endtask

    task automatic drain_responses();
        @(posedge clk_in);
        req_valid  <= 1'b0;
        fill_valid <= 1'b0;
        resp_ready <= 1'b1;
        @(negedge clk_in);
        #1;
        while (addr_q.size() != 0 || exp_hit_q.size() != 0 || resp_valid)
        begin
            @(negedge clk_in);
            #1;
        end
    endtask

    task automatic fill_every_set();
        cache_addr_t f;
        for (int i = 0; i < NUM_SET; i++)
        begin
            @(posedge clk_in);
            f.index = cache_index_t'(i);
            f.tag   = cache_tag_t'($random(seed) & 3);
            full_filled[i] = 1'b1;
            fill_valid <= 1'b1;
            fill_addr  <= f;
            fill_mask  <= '1;
            fill_data  <= {$random(seed), $random(seed)};
        end
        @(posedge clk_in);
        fill_valid <= 1'b0;
    endtask

    initial
    begin
        reset_in     = 1'b1;
        req_valid    = 1'b0;
        req_addr     = '0;
        resp_ready   = 1'b1;
        fill_valid   = 1'b0;
        fill_addr    = '0;
        fill_mask    = '0;
        fill_data    = '0;
        resp_busy    = 1'b0;
        seen_request = 1'b0;
        for (int i = 0; i < NUM_SET; i++)
        begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
            model_line[i]  = '0;
            full_filled[i] = 1'b0;
        end
        repeat (5) @(posedge clk_in);
        reset_in <= 1'b0;
        repeat (3) @(posedge clk_in);

        run_phase(20, 100, 0, 100, 1'b0, 1'b0);
        drain_responses();
        fill_every_set();
        run_phase(60, 100, 0, 100, 1'b0, 1'b0);
        drain_responses();
        run_phase(60, 80, 40, 100, 1'b1, 1'b0);
        drain_responses();
        run_phase(60, 80, 70, 30, 1'b1, 1'b1);
        drain_responses();
        run_phase(100, 70, 40, 50, 1'b1, 1'b0);
        drain_responses();

        if (addr_q.size() == 0 && exp_hit_q.size() == 0)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
        begin
            fail_run("requests were left without a response");
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        fail_run("watchdog expired before the test finished");
    end

endmodule

`default_nettype wire

// File: testbench/direct_mapped_cache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module direct_mapped_cache_sva
    import cache_pkg::*;
(
    input wire logic        clk_in,
    input wire logic        reset_in,
    input wire logic        req_ready,
    input wire logic        resp_valid,
    input wire logic        resp_ready,
    input wire logic        resp_hit,
    input wire cache_line_t resp_data
);

    // The response register is empty on the first edge after reset.
    assert property (@(posedge clk_in) reset_in |=> !resp_valid)
    else $error("resp_valid is high after reset");

    // A stalled response holds until it is taken.
    assert property (@(posedge clk_in) disable iff (reset_in)
        (resp_valid && !resp_ready) |=>
            (resp_valid && $stable(resp_hit) && $stable(resp_data)))
    else $error("stalled response changed before it was taken");

    assert property (@(posedge clk_in) disable iff (reset_in)
        !req_ready |-> (resp_valid && !resp_ready))
    else $error("req_ready is low without back-pressure");

endmodule

bind direct_mapped_cache direct_mapped_cache_sva i_sva
(
    .clk_in     (clk_in),
    .reset_in   (reset_in),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_hit   (resp_hit),
    .resp_data  (resp_data)
);

`default_nettype wire

// File: logic/direct_mapped_cache.sv
`timescale 1ns/1ps
`default_nettype none

module direct_mapped_cache
    import cache_pkg::*;
(
    input  wire logic        clk_in,
    input  wire logic        reset_in,

    // Lookup request.
    input  wire logic        req_valid,
    output logic             req_ready,
    input  wire cache_addr_t req_addr,

    // Lookup response. Data is only meaningful on a hit.
    output logic             resp_valid,
    input  wire logic        resp_ready,
    output logic             resp_hit,
    output cache_line_t      resp_data,

    // Fill port. A fill is accepted in every cycle it is valid.
    input  wire logic        fill_valid,
    input  wire cache_addr_t fill_addr,
    input  wire cache_mask_t fill_mask,
    input  wire cache_line_t fill_data
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup controller with its tag and line stores
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    cache_lookup i_lookup
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),

        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),

        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_hit   (resp_hit),
        .resp_data  (resp_data),

        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_mask  (fill_mask),
        .fill_data  (fill_data)
    );

endmodule

`default_nettype wire

// File: logic/cache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_lookup
    import cache_pkg::*;
(
    input  wire logic        clk_in,
    input  wire logic        reset_in,

    input  wire logic        req_valid,
    output logic             req_ready,
    input  wire cache_addr_t req_addr,

    output logic             resp_valid,
    input  wire logic        resp_ready,
    output logic             resp_hit,
    output cache_line_t      resp_data,

    input  wire logic        fill_valid,
    input  wire cache_addr_t fill_addr,
    input  wire cache_mask_t fill_mask,
    input  wire cache_line_t fill_data
);

    localparam int TAG_MASK_BITS = $bits(cache_tag_t) / `CACHE_BYTE_BITS;
    localparam int LINE_LANES    = $bits(cache_mask_t);

    logic                     s1_valid;
    cache_tag_t               s1_tag;
    cache_index_t             s1_index;
    logic                     s2_valid;
    logic                     s2_hit;
    cache_line_t              s2_data;

    logic                     accept;
    logic                     s2_free;
    logic                     s1_stall;
    logic                     rd_en;
    cache_index_t             rd_index;
    logic [TAG_MASK_BITS-1:0] tag_wr_mask;
    cache_tag_t               tag_rd;
    logic                     tag_rd_valid;
    cache_line_t              line_rd;

    logic                     fill_to_s1;
    cache_tag_t               tag_next;
    logic                     tag_valid_next;
    cache_line_t              line_next;
    logic                     hit_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake and RAM addressing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign s2_free   = !s2_valid || resp_ready;
    assign s1_stall  = s1_valid && !s2_free;
    assign req_ready = !s1_valid || s2_free;
    assign accept    = req_valid && req_ready;

    // A stalled item re-reads its own set so that fills keep reaching it.
    assign rd_en    = accept || s1_stall;
    assign rd_index = accept ? req_addr.index : s1_index;

    // Any written byte of the line refreshes the whole tag.
    assign tag_wr_mask = {TAG_MASK_BITS{|fill_mask}};

    dual_port_lutram
    #(
        .entry_t     (cache_tag_t),
        .NUM_SET     (`CACHE_NUM_SET),
        .WRITE_FIRST (1'b1),
        .WITH_VALID  (1'b1)
    )
    tag_store
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .write_en   (fill_valid),
        .write_mask (tag_wr_mask),
        .write_addr (fill_addr.index),
        .write_data (fill_addr.tag),
        .read_en    (rd_en),
        .read_addr  (rd_index),
        .read_data  (tag_rd),
        .read_valid (tag_rd_valid)
    );

    dual_port_lutram
    #(
        .entry_t     (cache_line_t),
        .NUM_SET     (`CACHE_NUM_SET),
        .WRITE_FIRST (1'b1),
        .WITH_VALID  (1'b0)
    )
    line_store
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .write_en   (fill_valid),
        .write_mask (fill_mask),
        .write_addr (fill_addr.index),
        .write_data (fill_data),
        .read_en    (rd_en),
        .read_addr  (rd_index),
        .read_data  (line_rd),
        .read_valid ()
    );

    // A fill on the edge that moves the item into stage two is merged here.
    assign fill_to_s1     = fill_valid && (fill_addr.index == s1_index);
    assign tag_valid_next = tag_rd_valid || (fill_to_s1 && (|fill_mask));
    assign tag_next       = (fill_to_s1 && (|fill_mask)) ? fill_addr.tag : tag_rd;
    assign hit_next       = tag_valid_next && (tag_next == s1_tag);

    always_comb
    begin
        line_next = line_rd;
        for (int lane = 0; lane < LINE_LANES; lane++)
        begin
            if (fill_to_s1 && fill_mask[lane])
            begin
                line_next[lane*`CACHE_BYTE_BITS +: `CACHE_BYTE_BITS] =
                    fill_data[lane*`CACHE_BYTE_BITS +: `CACHE_BYTE_BITS];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                s1_valid <= 1'b1;
            end
            else if (s2_free)
            begin
                s1_valid <= 1'b0;
            end
            if (s2_free)
            begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            s1_tag   <= req_addr.tag;
            s1_index <= req_addr.index;
        end
        if (s2_free && s1_valid)
        begin
            s2_hit  <= hit_next;
            s2_data <= line_next;
        end
    end

    assign resp_valid = s2_valid;
    assign resp_hit   = s2_hit;
    assign resp_data  = s2_data;

endmodule

`default_nettype wire

// File: logic/dual_port_lutram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module dual_port_lutram
#(
    parameter type entry_t     = logic [63:0],
    parameter int  NUM_SET     = 16,
    parameter bit  WRITE_FIRST = 1'b1,
    parameter bit  WITH_VALID  = 1'b1,
    localparam int ENTRY_BITS  = $bits(entry_t),
    localparam int MASK_BITS   = ENTRY_BITS / `CACHE_BYTE_BITS,
    localparam int ADDR_BITS   = $clog2(NUM_SET)
)
(
    input  wire logic                 clk_in,
    input  wire logic                 reset_in,

    input  wire logic                 write_en,
    input  wire logic [MASK_BITS-1:0] write_mask,
    input  wire logic [ADDR_BITS-1:0] write_addr,
    input  wire entry_t               write_data,

    input  wire logic                 read_en,
    input  wire logic [ADDR_BITS-1:0] read_addr,
    output entry_t                    read_data,
    output logic                      read_valid
);

    logic [ENTRY_BITS-1:0] mem [NUM_SET];

    logic [ENTRY_BITS-1:0] write_bits;
    logic [ENTRY_BITS-1:0] write_merged;
    logic                  write_any;
    logic                  forward;

    assign write_bits = write_data;
    assign write_any  = write_en && (|write_mask);

    // A same-set read in the write cycle sees the merged word.
    assign forward = write_any && read_en && (read_addr == write_addr);

    // The stored word with the enabled byte lanes replaced.
    always_comb
    begin
        write_merged = mem[write_addr];
        for (int lane = 0; lane < MASK_BITS; lane++)
        begin
            if (write_mask[lane])
            begin
                write_merged[lane*`CACHE_BYTE_BITS +: `CACHE_BYTE_BITS] =
                    write_bits[lane*`CACHE_BYTE_BITS +: `CACHE_BYTE_BITS];
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (write_any)
        begin
            mem[write_addr] <= write_merged;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    if (WRITE_FIRST)
    begin : g_write_first
        // The output holds its last value while the port is idle.
        always_ff @(posedge clk_in)
        begin
            if (forward)
            begin
                read_data <= entry_t'(write_merged);
            end
            else if (read_en)
            begin
                read_data <= entry_t'(mem[read_addr]);
            end
        end
    end
    else
    begin : g_read_first
        always_ff @(posedge clk_in)
        begin
            if (read_en)
            begin
                read_data <= entry_t'(mem[read_addr]);
            end
            else
            begin
                read_data <= '0;
            end
        end
    end

    if (WITH_VALID)
    begin : g_valid
        logic [NUM_SET-1:0] valid_array;

        always_ff @(posedge clk_in)
        begin
            if (reset_in)
            begin
                valid_array <= '0;
                read_valid  <= 1'b0;
            end
            else
            begin
                if (write_any)
                begin
                    valid_array[write_addr] <= 1'b1;
                end
                if (read_en)
                begin
                    read_valid <= valid_array[read_addr] || (WRITE_FIRST && forward);
                end
                else
                begin
                    read_valid <= 1'b0;
                end
            end
        end
    end
    else
    begin : g_no_valid
        // Without a valid array every entry counts as present.
        always_ff @(posedge clk_in)
        begin
            if (reset_in)
            begin
                read_valid <= 1'b0;
            end
            else
            begin
                read_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/cache_pkg.sv
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    localparam int CACHE_INDEX_BITS = $clog2(`CACHE_NUM_SET);

    typedef logic [CACHE_INDEX_BITS-1:0] cache_index_t;

    typedef logic [`CACHE_TAG_BITS-1:0] cache_tag_t;

    // Line address as seen by both clients.
    typedef struct packed {
        cache_tag_t   tag;
        cache_index_t index;
    } cache_addr_t;

    typedef logic [`CACHE_LINE_BITS-1:0] cache_line_t;

    // One enable per byte lane of a line.
    typedef logic [`CACHE_LINE_BITS/`CACHE_BYTE_BITS-1:0] cache_mask_t;

endpackage

`default_nettype wire

// File: logic/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Width of one write lane of the RAMs.
`define CACHE_BYTE_BITS 8

// Number of sets. It must be a power of two.
`define CACHE_NUM_SET 16

// Stored tag width in whole bytes so that the tag can be byte-masked.
`define CACHE_TAG_BITS 16

`define CACHE_LINE_BITS 64

`endif
